/* verif/stim_writes.txt */
# word index (hex), data word (hex), idle cycles after the push (decimal)
# 20 contiguous indices, then isolated ones, then a short run
010 5a5a000000000010 0
011 5a5a000000000011 0
012 5a5a000000000012 0
013 5a5a000000000013 0
014 5a5a000000000014 0
015 5a5a000000000015 0
016 5a5a000000000016 0
017 5a5a000000000017 0
018 5a5a000000000018 0
019 5a5a000000000019 0
01a 5a5a00000000001a 0
01b 5a5a00000000001b 0
01c 5a5a00000000001c 0
01d 5a5a00000000001d 0
01e 5a5a00000000001e 0
01f 5a5a00000000001f 0
020 5a5a000000000020 0
021 5a5a000000000021 0
022 5a5a000000000022 0
023 5a5a000000000023 0
030 c3c3000000000030 0
032 c3c3000000000032 1
034 c3c3000000000034 0
036 c3c3000000000036 2
038 c3c3000000000038 0
03a c3c300000000003a 4
03c c3c300000000003c 1
03e c3c300000000003e 0
040 c3c3000000000040 3
042 c3c3000000000042 0
005 c3c3000000000005 0
046 c3c3000000000046 1
048 c3c3000000000048 0
04a c3c300000000004a 5
04c c3c300000000004c 0
04e c3c300000000004e 2
050 c3c3000000000050 0
052 c3c3000000000052 1
054 c3c3000000000054 0
056 c3c3000000000056 0
058 c3c3000000000058 3
05a c3c300000000005a 0
05c c3c300000000005c 1
05e c3c300000000005e 0
060 c3c3000000000060 0
062 c3c3000000000062 2
064 c3c3000000000064 0
066 c3c3000000000066 0
068 c3c3000000000068 1
06a c3c300000000006a 0
06c c3c300000000006c 0
06e c3c300000000006e 4
080 9e9e000000000080 0
081 9e9e000000000081 0
082 9e9e000000000082 0
083 9e9e000000000083 0

/* src.f */
+incdir+verif
hw/mmap_cfg_pkg.sv
hw/axi_pkg.sv
hw/sync_fifo.sv
hw/burst_detector.sv
hw/wlast_gen.sv
hw/write_data_path.sv
hw/write_resp_path.sv
hw/async_mmap_wr.sv
verif/async_mmap_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' src.f)

.PHONY: run clean

run: obj_dir/Vasync_mmap_tb
	./obj_dir/Vasync_mmap_tb | tee sim.log
	! grep -q "STATUS: FAIL" sim.log
	grep -q "STATUS: PASS" sim.log

obj_dir/Vasync_mmap_tb: src.f $(SRCS) verif/tb_checks.svh
	verilator --binary --timing --assert -f src.f \
		--top-module async_mmap_tb -Mdir obj_dir -o Vasync_mmap_tb

clean:
	rm -rf obj_dir sim.log

/* verif/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// cycle limits for each kind of wait
localparam int PUSH_TIMEOUT   = 2000;
localparam int BREADY_TIMEOUT = 1000;
localparam int FULL_TIMEOUT   = 5000;
localparam int DRAIN_TIMEOUT  = 20000;

task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  end
endtask

task automatic check_data(input string name, input data_t expected, input data_t actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  end
endtask

task automatic check_len(input string name, input axi_len_t expected, input axi_len_t actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
  end
endtask

task automatic check_size(input string name, input axi_size_t expected,
                          input axi_size_t actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("mismatch %s expected %0d actual %0d", name, expected, actual));
  end
endtask

task automatic check_burst(input string name, input axi_burst_t expected,
                           input axi_burst_t actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
  end
endtask

task automatic check_last(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    stop_on_error($sformatf("mismatch %s expected %b actual %b", name, expected, actual));
  end
endtask

// returns on the first edge where the address queue has room
task automatic hold_until_addr_room();
  int cycles;
  cycles = 0;
  do begin
    @(posedge clk);
    cycles++;
    if (cycles > PUSH_TIMEOUT) begin
      stop_on_error("timeout: address queue never had room for the next write");
    end
  end while (write_addr_full_n !== 1'b1);
endtask

task automatic hold_until_data_room();
  int cycles;
  cycles = 0;
  do begin
    @(posedge clk);
    cycles++;
    if (cycles > PUSH_TIMEOUT) begin
      stop_on_error("timeout: data queue never had room for the next word");
    end
  end while (write_data_full_n !== 1'b1);
endtask

// bvalid is already high so the edge that sees bready completes the transfer
task automatic expect_bready();
  int cycles;
  cycles = 0;
  do begin
    @(posedge clk);
    cycles++;
    if (cycles > BREADY_TIMEOUT) begin
      stop_on_error("timeout: bready stayed low while a response was offered");
    end
  end while (bready !== 1'b1);
endtask

task automatic watch_addr_full();
  int cycles;
  cycles = 0;
  do begin
    @(posedge clk);
    cycles++;
    if (cycles > FULL_TIMEOUT) begin
      stop_on_error("timeout: address queue never filled while responses were held back");
    end
  end while (!(rst_n && write_addr_full_n === 1'b0));
endtask

task automatic drain_traffic();
  int cycles;
  cycles = 0;
  while (covered_writes != stim_idx.size() || w_data_log.size() != stim_idx.size() ||
         resp_log.size() != aw_len_log.size()) begin
    @(posedge clk);
    cycles++;
    if (cycles > DRAIN_TIMEOUT) begin
      stop_on_error("timeout: writes, beats or responses did not drain");
    end
  end
endtask

`endif

/* verif/async_mmap_tb.sv */
`timescale 1ns/10ps

module async_mmap_tb;

  import mmap_cfg_pkg::*;
  import axi_pkg::*;

  localparam addr_t OFFSET = 32'h4000_1000;

  // 8-byte words in incrementing bursts
  localparam axi_size_t  EXP_AWSIZE  = 3'd3;
  localparam axi_burst_t EXP_AWBURST = 2'b01;

  logic       clk = 1'b0;
  logic       rst_n = 1'b0;
  addr_t      offset = OFFSET;
  addr_t      write_addr_din = '0;
  logic       write_addr_write = 1'b0;
  logic       write_addr_full_n;
  data_t      write_data_din = '0;
  logic       write_data_write = 1'b0;
  logic       write_data_full_n;
  logic       awvalid;
  logic       awready = 1'b0;
  addr_t      awaddr;
  axi_len_t   awlen;
  axi_size_t  awsize;
  axi_burst_t awburst;
  logic       wvalid;
  logic       wready = 1'b0;
  data_t      wdata;
  logic       wlast;
  logic       bvalid = 1'b0;
  logic       bready;
  axi_len_t   write_resp_dout;
  logic       write_resp_read = 1'b0;
  logic       write_resp_empty_n;

  // one stimulus entry per write
  addr_t    stim_idx[$];
  data_t    stim_data[$];
  int       stim_idle[$];

  // what the slave side observed
  addr_t    aw_addr_log[$];
  axi_len_t aw_len_log[$];
  data_t    w_data_log[$];
  logic     w_last_log[$];
  axi_len_t resp_log[$];
  int       covered_writes = 0;
  int       bursts_done = 0;

  async_mmap_wr dut_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .offset            (offset),
    .write_addr_din    (write_addr_din),
    .write_addr_write  (write_addr_write),
    .write_addr_full_n (write_addr_full_n),
    .write_data_din    (write_data_din),
    .write_data_write  (write_data_write),
    .write_data_full_n (write_data_full_n),
    .awvalid           (awvalid),
    .awready           (awready),
    .awaddr            (awaddr),
    .awlen             (awlen),
    .awsize            (awsize),
    .awburst           (awburst),
    .wvalid            (wvalid),
    .wready            (wready),
    .wdata             (wdata),
    .wlast             (wlast),
    .bvalid            (bvalid),
    .bready            (bready),
    .write_resp_dout   (write_resp_dout),
    .write_resp_read   (write_resp_read),
    .write_resp_empty_n(write_resp_empty_n)
  );

  always #20 clk = ~clk;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "tb_checks.svh"

  task automatic load_stimulus();
    int    fd;
    string line;
    addr_t idx;
    data_t dat;
    int    idle;
    fd = $fopen("verif/stim_writes.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open verif/stim_writes.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // comment lines fail the first hex field and are skipped
      if ($sscanf(line, "%h %h %d", idx, dat, idle) == 3) begin
        stim_idx.push_back(idx);
        stim_data.push_back(dat);
        stim_idle.push_back(idle);
      end
    end
    $fclose(fd);
    if (stim_idx.size() == 0) begin
      stop_on_error("stimulus file holds no writes");
    end
  endtask

  // walks AW bursts in issue order against the stimulus
  task automatic score_bursts();
    int    w;
    addr_t exp_addr;
    w = 0;
    for (int b = 0; b < aw_addr_log.size(); b++) begin
      if (int'(aw_len_log[b]) > MAX_BURST_LEN) begin
        stop_on_error($sformatf("burst %0d has awlen %0d, above the burst limit",
                                b, aw_len_log[b]));
      end
      check_len($sformatf("response %0d", b), aw_len_log[b], resp_log[b]);
      for (int k = 0; k <= int'(aw_len_log[b]); k++) begin
        if (w >= stim_idx.size()) begin
          stop_on_error("AW bursts cover more writes than were pushed");
        end
        exp_addr = OFFSET + stim_idx[w] * 8;
        check_addr($sformatf("burst %0d beat %0d address", b, k), exp_addr,
                   aw_addr_log[b] + addr_t'(k * 8));
        check_data($sformatf("write %0d data", w), stim_data[w], w_data_log[w]);
        check_last($sformatf("write %0d wlast", w), k == int'(aw_len_log[b]), w_last_log[w]);
        w++;
      end
    end
    if (w != stim_idx.size()) begin
      stop_on_error("AW bursts do not cover every pushed write");
    end
  endtask

  // random but repeatable slave ready signals
  always @(posedge clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
    end else begin
      awready <= ($urandom % 4) != 0;
      wready  <= ($urandom % 3) != 0;
    end
  end

  // one pop every other cycle and never while empty
  always @(posedge clk) begin
    if (!rst_n) begin
      write_resp_read <= 1'b0;
    end else begin
      write_resp_read <= write_resp_empty_n && !write_resp_read;
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (awvalid && awready) begin
        check_size($sformatf("burst %0d awsize", aw_addr_log.size()), EXP_AWSIZE, awsize);
        check_burst($sformatf("burst %0d awburst", aw_addr_log.size()), EXP_AWBURST,
                    awburst);
        aw_addr_log.push_back(awaddr);
        aw_len_log.push_back(awlen);
        covered_writes += int'(awlen) + 1;
      end
      if (wvalid && wready) begin
        w_data_log.push_back(wdata);
        w_last_log.push_back(wlast);
        if (wlast) begin
          bursts_done++;
        end
      end
      if (write_resp_read && write_resp_empty_n) begin
        resp_log.push_back(write_resp_dout);
      end
    end
  end

  // B responses held back until the user's address queue backs up
  initial begin : b_responder
    int b_sent;
    b_sent = 0;
    watch_addr_full();
    forever begin
      @(posedge clk);
      if (b_sent < bursts_done && b_sent < aw_len_log.size()) begin
        repeat ($urandom % 4) @(posedge clk);
        bvalid <= 1'b1;
        expect_bready();
        bvalid <= 1'b0;
        b_sent++;
      end
    end
  end

  initial begin : run_test
    void'($urandom(32'hafce));
    load_stimulus();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    fork
      begin
        for (int i = 0; i < stim_idx.size(); i++) begin
          hold_until_addr_room();
          write_addr_din   <= stim_idx[i];
          write_addr_write <= 1'b1;
          @(posedge clk);
          write_addr_write <= 1'b0;
          repeat (stim_idle[i]) @(posedge clk);
        end
      end
      begin
        for (int i = 0; i < stim_data.size(); i++) begin
          hold_until_data_room();
          write_data_din   <= stim_data[i];
          write_data_write <= 1'b1;
          @(posedge clk);
          write_data_write <= 1'b0;
        end
      end
    join
    drain_traffic();
    score_bursts();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* hw/async_mmap_wr.sv */
`timescale 1ns/10ps
`default_nettype none

module async_mmap_wr (
  input  logic                  clk,
  input  logic                  rst_n,

  // base of the memory region
  input  mmap_cfg_pkg::addr_t   offset,

  // user pushes word indices and data
  input  mmap_cfg_pkg::addr_t   write_addr_din,
  input  logic                  write_addr_write,
  output logic                  write_addr_full_n,
  input  mmap_cfg_pkg::data_t   write_data_din,
  input  logic                  write_data_write,
  output logic                  write_data_full_n,

  // AW channel
  output logic                  awvalid,
  input  logic                  awready,
  output mmap_cfg_pkg::addr_t   awaddr,
  output axi_pkg::axi_len_t     awlen,
  output axi_pkg::axi_size_t    awsize,
  output axi_pkg::axi_burst_t   awburst,

  // W channel
  output logic                  wvalid,
  input  logic                  wready,
  output mmap_cfg_pkg::data_t   wdata,
  output logic                  wlast,

  // B channel
  input  logic                  bvalid,
  output logic                  bready,

  // user pops completed burst lengths
  output axi_pkg::axi_len_t     write_resp_dout,
  input  logic                  write_resp_read,
  output logic                  write_resp_empty_n
);

  import mmap_cfg_pkg::*;
  import axi_pkg::*;

  // index to byte address
  addr_t      byte_addr;
  addr_t      addr_dout;
  logic       addr_empty_n;
  logic       addr_read;

  burst_req_t req_din;
  logic       req_write;
  logic       req_full_n;
  burst_req_t req_dout;
  logic       aw_pop;

  axi_len_t   len_din;
  logic       len_write;
  logic       len_full_n;
  axi_len_t   len_dout;
  logic       len_empty_n;
  logic       len_read;

  axi_len_t   pend_din;
  logic       pend_write;
  logic       pend_full_n;

  logic       last_din;
  logic       last_write;
  logic       last_full_n;

  assign byte_addr = offset + (write_addr_din << BYTES_LOG);

  sync_fifo #(.payload_t(addr_t)) addr_q (
    .clk    (clk),
    .rst_n  (rst_n),
    .write  (write_addr_write),
    .din    (byte_addr),
    .full_n (write_addr_full_n),
    .read   (addr_read),
    .empty_n(addr_empty_n),
    .dout   (addr_dout)
  );

  burst_detector burst_det_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .addr_dout   (addr_dout),
    .addr_empty_n(addr_empty_n),
    .addr_read   (addr_read),
    .req_din     (req_din),
    .req_full_n  (req_full_n),
    .req_write   (req_write),
    .len_din     (len_din),
    .len_full_n  (len_full_n),
    .len_write   (len_write),
    .pend_din    (pend_din),
    .pend_full_n (pend_full_n),
    .pend_write  (pend_write)
  );

  // AW queue head drives the channel directly
  sync_fifo #(.payload_t(burst_req_t)) aw_q (
    .clk    (clk),
    .rst_n  (rst_n),
    .write  (req_write),
    .din    (req_din),
    .full_n (req_full_n),
    .read   (aw_pop),
    .empty_n(awvalid),
    .dout   (req_dout)
  );

  assign aw_pop  = awvalid && awready;
  assign awaddr  = req_dout.addr;
  assign awlen   = req_dout.len;
  assign awsize  = axi_size_t'(BYTES_LOG);
  assign awburst = AXI_BURST_INCR;

  sync_fifo #(.payload_t(axi_len_t)) len_q (
    .clk    (clk),
    .rst_n  (rst_n),
    .write  (len_write),
    .din    (len_din),
    .full_n (len_full_n),
    .read   (len_read),
    .empty_n(len_empty_n),
    .dout   (len_dout)
  );

  wlast_gen wlast_gen_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .len_dout   (len_dout),
    .len_empty_n(len_empty_n),
    .len_read   (len_read),
    .last_din   (last_din),
    .last_full_n(last_full_n),
    .last_write (last_write)
  );

  write_data_path wr_data_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .data_din   (write_data_din),
    .data_write (write_data_write),
    .data_full_n(write_data_full_n),
    .last_din   (last_din),
    .last_write (last_write),
    .last_full_n(last_full_n),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wlast      (wlast)
  );

  write_resp_path wr_resp_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pend_din    (pend_din),
    .pend_write  (pend_write),
    .pend_full_n (pend_full_n),
    .bvalid      (bvalid),
    .bready      (bready),
    .resp_dout   (write_resp_dout),
    .resp_read   (write_resp_read),
    .resp_empty_n(write_resp_empty_n)
  );

endmodule

`default_nettype wire

/* hw/write_resp_path.sv */
`timescale 1ns/10ps
`default_nettype none

module write_resp_path (
  input  logic              clk,
  input  logic              rst_n,

  // outstanding bursts from the detector
  input  axi_pkg::axi_len_t pend_din,
  input  logic              pend_write,
  output logic              pend_full_n,

  // B channel
  input  logic              bvalid,
  output logic              bready,

  // completed bursts to the user
  output axi_pkg::axi_len_t resp_dout,
  input  logic              resp_read,
  output logic              resp_empty_n
);

  import axi_pkg::*;

  axi_len_t pend_dout;
  logic     pend_empty_n;
  logic     resp_full_n;
  logic     b_xfer;

  // only accept a response that has a burst to pair with
  assign bready = pend_empty_n && resp_full_n;
  assign b_xfer = bvalid && bready;

  sync_fifo #(.payload_t(axi_len_t)) pend_q (
    .clk    (clk),
    .rst_n  (rst_n),
    .write  (pend_write),
    .din    (pend_din),
    .full_n (pend_full_n),
    .read   (b_xfer),
    .empty_n(pend_empty_n),
    .dout   (pend_dout)
  );

  sync_fifo #(.payload_t(axi_len_t)) resp_q (
    .clk    (clk),
    .rst_n  (rst_n),
    .write  (b_xfer),
    .din    (pend_dout),
    .full_n (resp_full_n),
    .read   (resp_read),
    .empty_n(resp_empty_n),
    .dout   (resp_dout)
  );

  // a B transfer consumes an outstanding burst and shows up for the user
  assert property (@(posedge clk) disable iff (!rst_n)
    bready |-> pend_empty_n)
    else $error("write_resp_path: bready without outstanding burst");
  assert property (@(posedge clk) disable iff (!rst_n)
    b_xfer |=> resp_empty_n)
    else $error("write_resp_path: response lost after B transfer");

endmodule

`default_nettype wire

/* hw/write_data_path.sv */
`timescale 1ns/10ps
`default_nettype none

module write_data_path (
  input  logic                clk,
  input  logic                rst_n,

  // user data words
  input  mmap_cfg_pkg::data_t data_din,
  input  logic                data_write,
  output logic                data_full_n,

  // last flags from the generator
  input  logic                last_din,
  input  logic                last_write,
  output logic                last_full_n,

  // W channel
  output logic                wvalid,
  input  logic                wready,
  output mmap_cfg_pkg::data_t wdata,
  output logic                wlast
);

  import mmap_cfg_pkg::*;

  logic data_empty_n;
  logic last_empty_n;
  logic beat_pop;

  // a beat needs both a data word and its flag
  assign wvalid   = data_empty_n && last_empty_n;
  assign beat_pop = wvalid && wready;

  sync_fifo #(.payload_t(data_t)) data_q (
    .clk    (clk),
    .rst_n  (rst_n),
    .write  (data_write),
    .din    (data_din),
    .full_n (data_full_n),
    .read   (beat_pop),
    .empty_n(data_empty_n),
    .dout   (wdata)
  );

  sync_fifo #(.payload_t(logic)) last_q (
    .clk    (clk),
    .rst_n  (rst_n),
    .write  (last_write),
    .din    (last_din),
    .full_n (last_full_n),
    .read   (beat_pop),
    .empty_n(last_empty_n),
    .dout   (wlast)
  );

  assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else $error("write_data_path: W beat changed while stalled");

endmodule

`default_nettype wire

/* hw/wlast_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module wlast_gen (
  input  logic              clk,
  input  logic              rst_n,

  // burst lengths in
  input  axi_pkg::axi_len_t len_dout,
  input  logic              len_empty_n,
  output logic              len_read,

  // one flag per data beat out
  output logic              last_din,
  input  logic              last_full_n,
  output logic              last_write
);

  import axi_pkg::*;

  // beat index within the current burst
  axi_len_t beat_q;

  assign last_write = len_empty_n && last_full_n;
  assign last_din   = (beat_q == len_dout);
  // length leaves the queue with its final beat
  assign len_read   = last_write && last_din;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else if (last_write) begin
      beat_q <= last_din ? '0 : beat_q + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    len_empty_n |-> beat_q <= len_dout)
    else $error("wlast_gen: beat counter past burst length");

endmodule

`default_nettype wire

/* hw/burst_detector.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_detector (
  input  logic                clk,
  input  logic                rst_n,

  // single byte addresses in
  input  mmap_cfg_pkg::addr_t addr_dout,
  input  logic                addr_empty_n,
  output logic                addr_read,

  // burst requests for the AW channel
  output axi_pkg::burst_req_t req_din,
  input  logic                req_full_n,
  output logic                req_write,

  // burst lengths for the last-flag generator
  output axi_pkg::axi_len_t   len_din,
  input  logic                len_full_n,
  output logic                len_write,

  // burst lengths for response tracking
  output axi_pkg::axi_len_t   pend_din,
  input  logic                pend_full_n,
  output logic                pend_write
);

  import mmap_cfg_pkg::*;
  import axi_pkg::*;

  // the open burst
  logic     open_q;
  addr_t    start_q;
  axi_len_t len_q;
  wait_t    wait_q;

  // registered emission
  logic     emit_q;
  addr_t    out_addr_q;
  axi_len_t out_len_q;

  logic  outs_ready;
  logic  pop;
  logic  extend;
  logic  timeout;
  logic  close_now;
  addr_t next_addr;

  // an emission still in flight has not reached the full_n inputs yet
  assign outs_ready = req_full_n && len_full_n && pend_full_n && !emit_q;
  assign pop        = addr_empty_n && outs_ready;
  assign addr_read  = pop;

  always_comb begin
    next_addr = start_q + ((addr_t'(len_q) + addr_t'(1)) << BYTES_LOG);
    extend    = open_q && (addr_dout == next_addr) &&
                (len_q < axi_len_t'(MAX_BURST_LEN));
    timeout   = !pop && outs_ready && (wait_q == wait_t'(MAX_WAIT));
    close_now = open_q && ((pop && !extend) || timeout);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      open_q <= 1'b0;
      len_q  <= '0;
      wait_q <= '0;
      emit_q <= 1'b0;
    end else begin
      emit_q <= close_now;
      if (pop) begin
        wait_q <= '0;
        if (extend) begin
          len_q <= len_q + 1'b1;
        end else begin
          // this address opens a fresh burst
          open_q <= 1'b1;
          len_q  <= '0;
        end
      end else if (close_now) begin
        open_q <= 1'b0;
        wait_q <= '0;
      end else if (open_q && wait_q != wait_t'(MAX_WAIT)) begin
        wait_q <= wait_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop && !extend) begin
      start_q <= addr_dout;
    end
    if (close_now) begin
      out_addr_q <= start_q;
      out_len_q  <= len_q;
    end
  end

  assign req_din    = '{addr: out_addr_q, len: out_len_q};
  assign req_write  = emit_q;
  assign len_din    = out_len_q;
  assign len_write  = emit_q;
  assign pend_din   = out_len_q;
  assign pend_write = emit_q;

  assert property (@(posedge clk) disable iff (!rst_n)
    emit_q |-> out_len_q <= axi_len_t'(MAX_BURST_LEN))
    else $error("burst_detector: emitted length above limit");

endmodule

`default_nettype wire

/* hw/sync_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     write,
  input  payload_t din,
  output logic     full_n,
  input  logic     read,
  output logic     empty_n,
  output payload_t dout
);

  import mmap_cfg_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t   mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign full_n  = (count_q != CNT_W'(FIFO_DEPTH));
  assign empty_n = (count_q != '0);
  // head entry is visible without a pop
  assign dout    = mem[rd_ptr_q];

  assign push = write && full_n;
  assign pop  = read && empty_n;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= din;
    end
  end

  // callers must respect the handshake
  assert property (@(posedge clk) disable iff (!rst_n) !(write && !full_n))
    else $error("sync_fifo: push while full");
  assert property (@(posedge clk) disable iff (!rst_n) !(read && !empty_n))
    else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

/* hw/axi_pkg.sv */
package axi_pkg;

  // AXI write address channel fields
  typedef logic [7:0] axi_len_t;
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;

  // burst type codes
  localparam axi_burst_t AXI_BURST_INCR = 2'b01;

  // one inferred burst, as queued for the AW channel
  typedef struct packed {
    mmap_cfg_pkg::addr_t addr;
    axi_len_t            len;
  } burst_req_t;

endpackage

/* hw/mmap_cfg_pkg.sv */
package mmap_cfg_pkg;

  // byte address and data word widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 64;
  // log2 of bytes per data word
  localparam int BYTES_LOG = 3;

  // entries in every queue of the master
  localparam int FIFO_DEPTH = 16;

  // burst inference limits
  localparam int MAX_WAIT      = 3;
  localparam int MAX_BURST_LEN = 15;
  localparam int WAIT_W        = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [WAIT_W-1:0] wait_t;

endpackage
